// ==== arc.f ====
arc_timing_pkg.sv
arc_op_pkg.sv
arc_decode.sv
arc_alu.sv
arc_regs.sv
arc_top.sv
arc_checker.sv
arc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the arc testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module arc_tb -f arc.f
out=$(./obj_dir/Varc_tb 2>&1) || true
printf '%s\n' "$out"
echo "$out" | grep -q "Simulation completed successfully"

// ==== arc_tb.sv ====
/*
 * Testbench for the arithmetic and register chip. Sends one serial
 * instruction per word from a table and reads A or carry back.
 */
module arc_tb;
	import arc_op_pkg::*;

	typedef enum logic [1:0] {
		chk_none, chk_a, chk_carry, chk_load
	} chk_e;

	// val holds BCD A, or carry in bit 0, or the number to load
	typedef struct packed {
		logic [6:0] instr;
		chk_e kind;
		logic [55:0] val;
	} entry_t;

	// Type 01 decodes to nothing
	localparam logic [6:0] nop_c = 7'b0000001;
	localparam int word_len = 56;
	localparam int start_limit = 200;

	logic cph2;
	logic ws;
	logic sync;
	logic is;
	logic start;
	logic carry;
	logic [3:0] a_digit;

	entry_t tbl[$];
	int passed;
	int failed;
	int stray_starts;
	logic timed_out;

	arc_top #(
		.num_digits(14)
	) dut_i (
		.cph2(cph2),
		.ws(ws),
		.sync(sync),
		.is(is),
		.start(start),
		.carry(carry),
		.a_digit(a_digit)
	);

	initial begin
		cph2 = 1'b0;
		forever #10 cph2 = ~cph2;
	end

	// Instruction word is {code, type}
	function automatic logic [6:0] arith_instr(input logic [4:0] code);
		return {code, 2'b10};
	endfunction

	function automatic logic [6:0] ldc_instr(input logic [3:0] n);
		return {n, 1'b0, 2'b00};
	endfunction

	function automatic entry_t make_row(input logic [6:0] instr, input chk_e kind,
		input logic [55:0] val);
		entry_t r;
		r.instr = instr;
		r.kind = kind;
		r.val = val;
		return r;
	endfunction

	task automatic build_table();
		// Reset state, then a known number through LDC
		tbl.push_back(make_row(nop_c, chk_a, 56'h0));
		tbl.push_back(make_row(nop_c, chk_load, 56'h12345678901234));
		// Number into B, second number into A, then add with and without wrap
		tbl.push_back(make_row(arith_instr(code_axb), chk_a, 56'h0));
		tbl.push_back(make_row(nop_c, chk_load, 56'h87654321098765));
		tbl.push_back(make_row(arith_instr(code_a_add_b), chk_a, 56'h99999999999999));
		tbl.push_back(make_row(nop_c, chk_carry, 56'd0));
		tbl.push_back(make_row(arith_instr(code_a_add_b), chk_a, 56'h12345678901233));
		tbl.push_back(make_row(nop_c, chk_carry, 56'd1));
		// Increment, decrement and subtract with borrow
		tbl.push_back(make_row(arith_instr(code_a_inc), chk_a, 56'h12345678901234));
		tbl.push_back(make_row(nop_c, chk_carry, 56'd0));
		tbl.push_back(make_row(arith_instr(code_a_dec), chk_a, 56'h12345678901233));
		tbl.push_back(make_row(arith_instr(code_a_sub_b), chk_a, 56'h99999999999999));
		tbl.push_back(make_row(nop_c, chk_carry, 56'd1));
		tbl.push_back(make_row(arith_instr(code_a_inc), chk_a, 56'h0));
		tbl.push_back(make_row(arith_instr(code_a_dec), chk_a, 56'h99999999999999));
		// Compares and zero test
		tbl.push_back(make_row(arith_instr(code_c_zero), chk_carry, 56'd0));
		tbl.push_back(make_row(arith_instr(code_axb), chk_a, 56'h12345678901234));
		tbl.push_back(make_row(arith_instr(code_cmp_ab), chk_carry, 56'd1));
		tbl.push_back(make_row(nop_c, chk_a, 56'h12345678901234));
		tbl.push_back(make_row(arith_instr(code_c_add_a), chk_carry, 56'd0));
		tbl.push_back(make_row(arith_instr(code_c_zero), chk_carry, 56'd1));
		tbl.push_back(make_row(arith_instr(code_cmp_ac), chk_carry, 56'd0));
		tbl.push_back(make_row(arith_instr(code_a_dec), chk_a, 56'h12345678901233));
		tbl.push_back(make_row(arith_instr(code_cmp_ac), chk_carry, 56'd1));
		tbl.push_back(make_row(nop_c, chk_a, 56'h12345678901233));
		// C results brought back through AXC
		tbl.push_back(make_row(arith_instr(code_c_add_a), chk_carry, 56'd0));
		tbl.push_back(make_row(arith_instr(code_axc), chk_a, 56'h24691357802467));
		tbl.push_back(make_row(arith_instr(code_c_sub_a), chk_a, 56'h24691357802467));
		tbl.push_back(make_row(arith_instr(code_axc), chk_a, 56'h12345678901234));
		tbl.push_back(make_row(arith_instr(code_c_sub_a), chk_carry, 56'd1));
		tbl.push_back(make_row(arith_instr(code_axc), chk_a, 56'h87654321098767));
		// Digit shifts and clears
		tbl.push_back(make_row(arith_instr(code_sla), chk_a, 56'h76543210987670));
		tbl.push_back(make_row(arith_instr(code_sra), chk_a, 56'h07654321098767));
		tbl.push_back(make_row(arith_instr(code_a_clr), chk_a, 56'h0));
		tbl.push_back(make_row(arith_instr(code_a_add_c), chk_a, 56'h12345678901234));
		tbl.push_back(make_row({code_clreg, 2'b00}, chk_a, 56'h0));
		tbl.push_back(make_row(arith_instr(code_axb), chk_a, 56'h0));
		tbl.push_back(make_row(arith_instr(code_axc), chk_a, 56'h0));
	endtask

	// Step cycle by cycle until start is high
	task automatic wait_start();
		int n;
		n = 0;
		while (!start && n < start_limit) begin
			@(posedge cph2);
			#1;
			n++;
		end
		if (!start)
			timed_out = 1'b1;
	endtask

	// Sync and is over bit-times 0..55 of one word, sampling A digits and carry
	task automatic run_word(input logic [6:0] instr, output logic [55:0] digits,
		output logic cy);
		int c;
		digits = '0;
		cy = 1'b0;
		wait_start();
		if (!timed_out) begin
			for (c = 0; c < word_len; c++) begin
				sync = (c >= 45 && c <= 54);
				if (c == 45 || c == 46)
					is = instr[c - 45];
				else if (c >= 50 && c <= 54)
					is = instr[c - 48];
				else
					is = 1'b0;
				// Digit k sits on a_digit over bit-times 4k+1 to 4k+4
				if (c % 4 == 2)
					digits[(c / 4) * 4 +: 4] = a_digit;
				if (c == 2)
					cy = carry;
				if (c != 0 && start)
					stray_starts++;
				@(posedge cph2);
				#1;
			end
		end
	endtask

	task automatic tally(input int idx, input logic ok);
		if (ok) begin
			passed++;
			$display("test %0d: pass", idx);
		end else begin
			failed++;
			$display("test %0d: fail", idx);
		end
	endtask

	task automatic check_entry(input int idx, input entry_t e, input logic [55:0] got,
		input logic cy);
		logic ok;
		if (e.kind == chk_none) begin
			ok = 1'b1;
		end else if (e.kind == chk_carry) begin
			ok = (cy == e.val[0]);
			assert (ok) else
				$display("FAIL t=%0t: test %0d carry expected %0b got %0b",
					$time, idx, e.val[0], cy);
		end else begin
			ok = (got === e.val);
			assert (ok) else
				$display("FAIL t=%0t: test %0d A expected %h got %h",
					$time, idx, e.val, got);
		end
		tally(idx, ok);
	endtask

	initial begin
		entry_t e;
		logic [55:0] got;
		logic cy;
		logic ok;
		int i;
		int d;
		ws = 1'b0;
		sync = 1'b0;
		is = 1'b0;
		passed = 0;
		failed = 0;
		stray_starts = 0;
		timed_out = 1'b0;
		build_table();
		repeat (2) @(posedge cph2);
		#1;
		ws = 1'b1;
		for (i = 0; i < tbl.size() && !timed_out; i++) begin
			e = tbl[i];
			// First LDC ends up in the lowest digit
			if (e.kind == chk_load) begin
				for (d = 0; d < 14; d++)
					run_word(ldc_instr(e.val[4 * d +: 4]), got, cy);
			end else begin
				run_word(e.instr, got, cy);
			end
			// Execute word, then read back in the word after
			run_word(nop_c, got, cy);
			run_word(nop_c, got, cy);
			if (!timed_out)
				check_entry(i, e, got, cy);
		end
		ok = (stray_starts == 0);
		assert (ok) else
			$display("FAIL t=%0t: %0d start pulses away from bit-time 0",
				$time, stray_starts);
		tally(tbl.size(), ok);
		if (timed_out)
			$display("Timeout: no start pulse within %0d cycles", start_limit);
		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0 && !timed_out)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== arc_checker.sv ====
/*
 * Bound assertions for the arithmetic and register chip.
 * Word period of start, flag update points and BCD readout range.
 */
module arc_checker (
	input logic cph2,
	input logic ws,
	input logic start,
	input logic carry,
	input logic zero_flag,
	input logic [3:0] a_digit
);
	// Cycles since the last start pulse
	logic [5:0] gap;
	// Set once the first start is seen
	logic aligned;

	always_ff @(posedge cph2 or negedge ws) begin
		if (!ws) begin
			gap <= '0;
			aligned <= 1'b0;
		end else if (start) begin
			gap <= '0;
			aligned <= 1'b1;
		end else begin
			gap <= gap + 6'd1;
		end
	end

	// Exactly one pulse every 56 bit-times
	start_period_a: assert property (@(posedge cph2) disable iff (!ws)
		aligned |-> (start == (gap == 6'd55)))
		else $error("start pulse outside its 56 cycle period");

	// Readout of A is always a decimal digit
	digit_bcd_a: assert property (@(posedge cph2) disable iff (!ws)
		a_digit <= 4'd9)
		else $error("a_digit above 9");

	// Carry moves only on the edge that raises start
	carry_update_a: assert property (@(posedge cph2) disable iff (!ws)
		(carry != $past(carry)) |-> start)
		else $error("carry changed away from the end of a word");

	// Zero flag is captured with carry at the word end
	zero_update_a: assert property (@(posedge cph2) disable iff (!ws)
		(zero_flag != $past(zero_flag)) |-> start)
		else $error("zero_flag changed away from the end of a word");

endmodule

bind arc_top arc_checker chk_i (
	.cph2(cph2),
	.ws(ws),
	.start(start),
	.carry(carry),
	.zero_flag(zero_flag),
	.a_digit(a_digit)
);

// ==== arc_top.sv ====
/*
 * Arithmetic and register chip top level.
 * Decode, serial ALU and register file on one word clock.
 */
module arc_top #(
	parameter int num_digits = 14
) (
	input logic cph2,
	input logic ws,
	input logic sync,
	input logic is,
	output logic start,
	output logic carry,
	output logic [3:0] a_digit
);
	import arc_timing_pkg::*;
	import arc_op_pkg::*;

	arc_strobe_t strobe;
	arc_ctl_t ctl;
	logic a_bit;
	logic op_bit;
	logic sum_bit;
	logic [2:0] adj_digit;
	// Result of the last ALU word was all zero
	logic zero_flag;

	arc_decode #(
		.num_digits(num_digits)
	) u_decode (
		.cph2(cph2),
		.ws(ws),
		.sync(sync),
		.is(is),
		.strobe(strobe),
		.ctl(ctl),
		.start(start)
	);

	arc_alu u_alu (
		.cph2(cph2),
		.ws(ws),
		.strobe(strobe),
		.ctl(ctl),
		.a_bit(a_bit),
		.op_bit(op_bit),
		.sum_bit(sum_bit),
		.adj_digit(adj_digit),
		.carry(carry),
		.zero_flag(zero_flag)
	);

	arc_regs #(
		.num_digits(num_digits)
	) u_regs (
		.cph2(cph2),
		.ws(ws),
		.strobe(strobe),
		.ctl(ctl),
		.sum_bit(sum_bit),
		.adj_digit(adj_digit),
		.a_bit(a_bit),
		.op_bit(op_bit),
		.a_digit(a_digit)
	);

endmodule

// ==== arc_regs.sv ====
/*
 * A, B and C rotating shift registers. Picks each register's input bit
 * per operation, writes corrected digits from the ALU and drives the
 * BCD readout of A.
 */
module arc_regs #(
	parameter int num_digits = 14
) (
	input logic cph2,
	input logic ws,
	input arc_timing_pkg::arc_strobe_t strobe,
	input arc_op_pkg::arc_ctl_t ctl,
	input logic sum_bit,
	input logic [2:0] adj_digit,
	output logic a_bit,
	output logic op_bit,
	output logic [3:0] a_digit
);
	import arc_timing_pkg::*;
	import arc_op_pkg::*;

	localparam int reg_w = num_digits * word_bits_c;

	logic [reg_w-1:0] a_r;
	logic [reg_w-1:0] b_r;
	logic [reg_w-1:0] c_r;
	logic [3:0] a_dly;
	logic a_in;
	logic b_in;
	logic c_in;
	logic a_load;
	logic c_load;
	logic [3:0] a_nib;
	logic [3:0] c_nib;

	// Rotate one bit right, or overwrite the digit just completed
	function automatic logic [reg_w-1:0] shift_in(input logic [reg_w-1:0] r,
		input logic in_bit, input logic nib_load, input logic [3:0] nib);
		if (nib_load)
			shift_in = {nib, r[reg_w-4:1]};
		else
			shift_in = {in_bit, r[reg_w-1:1]};
	endfunction

	assign a_bit = a_r[0];

	always_comb begin
		case (ctl.operand_sel)
			opnd_b: op_bit = b_r[0];
			opnd_c: op_bit = c_r[0];
			// Constant 1 goes in as carry
			default: op_bit = 1'b0;
		endcase
	end

	// A input select
	always_comb begin
		a_in = a_r[0];
		a_load = 1'b0;
		// Corrected upper bits over the raw ones
		a_nib = {adj_digit, a_r[reg_w-3]};
		if (ctl.dest_a) begin
			a_in = sum_bit;
			a_load = strobe.t4km1;
		end else begin
			case (ctl.op)
				op_a_clr, op_clreg: a_in = 1'b0;
				op_axb: a_in = b_r[0];
				op_axc: a_in = c_r[0];
				// Digit from four bits back
				op_sla: a_in = a_dly[0];
				op_sra: begin
					a_in = a_r[4];
					a_load = strobe.t55;
					a_nib = 4'h0;
				end
				// Shift right, n into the top digit
				op_ldc: begin
					a_in = a_r[4];
					a_load = strobe.t55;
					a_nib = ctl.const_n;
				end
				default: a_in = a_r[0];
			endcase
		end
	end

	// B only clears or swaps
	always_comb begin
		case (ctl.op)
			op_axb: b_in = a_r[0];
			op_clreg: b_in = 1'b0;
			default: b_in = b_r[0];
		endcase
	end

	// C input select
	always_comb begin
		c_in = c_r[0];
		c_load = 1'b0;
		c_nib = {adj_digit, c_r[reg_w-3]};
		if (ctl.dest_c) begin
			c_in = sum_bit;
			c_load = strobe.t4km1;
		end else begin
			case (ctl.op)
				op_c_clr, op_clreg: c_in = 1'b0;
				op_axc: c_in = a_r[0];
				default: c_in = c_r[0];
			endcase
		end
	end

	// Zeros for the first digit of a left shift
	always_ff @(posedge cph2) begin
		if (strobe.t55)
			a_dly <= 4'h0;
		else
			a_dly <= {a_r[0], a_dly[3:1]};
	end

	always_ff @(posedge cph2 or negedge ws) begin
		if (!ws) begin
			a_r <= '0;
			b_r <= '0;
			c_r <= '0;
			a_digit <= 4'h0;
		end else begin
			a_r <= shift_in(a_r, a_in, a_load, a_nib);
			b_r <= shift_in(b_r, b_in, 1'b0, 4'h0);
			c_r <= shift_in(c_r, c_in, c_load, c_nib);
			// Whole digit sits in the low nibble here
			if (strobe.t4k)
				a_digit <= a_r[3:0];
		end
	end

endmodule

// ==== arc_alu.sv ====
/*
 * Bit-serial decimal adder and subtractor. Binary full add or subtract
 * per bit, digit correction at each digit's last bit, and the carry
 * flag captured at the end of the word.
 */
module arc_alu (
	input logic cph2,
	input logic ws,
	input arc_timing_pkg::arc_strobe_t strobe,
	input arc_op_pkg::arc_ctl_t ctl,
	input logic a_bit,
	input logic op_bit,
	output logic sum_bit,
	output logic [2:0] adj_digit,
	output logic carry,
	output logic zero_flag
);
	import arc_op_pkg::*;

	logic cy_r;
	logic cy_in;
	logic raw_sum;
	logic raw_cout;
	logic [2:0] dly;
	logic [3:0] digit4;
	logic [3:0] fix;
	logic dec_cy;
	logic cy_nxt;
	logic test_mode;
	logic digit_nz;
	logic nz_r;

	assign test_mode = (ctl.op == op_c_zero_test);

	// Increment and decrement inject their 1 as carry-in
	assign cy_in = strobe.t0 ? (ctl.operand_sel == opnd_one) : cy_r;

	always_comb begin
		if (test_mode) begin
			// C alone, carry just remembers a set bit
			raw_sum = op_bit;
			raw_cout = op_bit | cy_in;
		end else if (ctl.subtract) begin
			raw_sum = a_bit ^ op_bit ^ cy_in;
			raw_cout = (!a_bit && (op_bit || cy_in)) || (op_bit && cy_in);
		end else begin
			raw_sum = a_bit ^ op_bit ^ cy_in;
			raw_cout = (a_bit && op_bit) || (cy_in && (a_bit || op_bit));
		end
	end

	// Whole binary digit once its fourth bit is here
	assign digit4 = {raw_sum, dly};

	always_comb begin
		fix = digit4;
		dec_cy = raw_cout;
		if (!test_mode) begin
			if (ctl.subtract) begin
				// Borrow out of the nibble, add ten back
				if (raw_cout)
					fix = digit4 + 4'd10;
			end else if (raw_cout || digit4 > 4'd9) begin
				// Above nine, take ten off and carry
				fix = digit4 + 4'd6;
				dec_cy = 1'b1;
			end
		end
	end

	// Bit 0 never changes with a correction of ten
	assign adj_digit = fix[3:1];
	assign sum_bit = raw_sum;
	assign digit_nz = |fix;
	assign cy_nxt = strobe.t4km1 ? dec_cy : raw_cout;

	// Low three bits of the current digit
	always_ff @(posedge cph2) begin
		dly <= {raw_sum, dly[2:1]};
	end

	always_ff @(posedge cph2 or negedge ws) begin
		if (!ws) begin
			cy_r <= 1'b0;
			nz_r <= 1'b0;
			carry <= 1'b0;
			zero_flag <= 1'b0;
		end else begin
			cy_r <= cy_nxt;
			if (strobe.t55)
				nz_r <= 1'b0;
			else if (strobe.t4km1)
				nz_r <= nz_r | digit_nz;
			// Non-ALU words leave both flags alone
			if (strobe.t55 && ctl.arith) begin
				carry <= cy_nxt;
				zero_flag <= !(nz_r || digit_nz);
			end
		end
	end

endmodule

// ==== arc_decode.sv ====
/*
 * Timing and instruction decode. Counts bit-times, realigns on the
 * falling edge of sync, shifts in the serial instruction and latches
 * its decoded control at the end of the word.
 */
module arc_decode #(
	parameter int num_digits = 14
) (
	input logic cph2,
	input logic ws,
	input logic sync,
	input logic is,
	output arc_timing_pkg::arc_strobe_t strobe,
	output arc_op_pkg::arc_ctl_t ctl,
	output logic start
);
	import arc_timing_pkg::*;
	import arc_op_pkg::*;

	localparam int word_len = num_digits * word_bits_c;
	localparam int cnt_w = $clog2(word_len);
	localparam int last_bit = word_len - 1;
	// Window sits at a fixed distance from the word end
	localparam int type_lo = last_bit - (word_end_c - type_first_c);
	localparam int type_hi = last_bit - (word_end_c - type_last_c);
	localparam int code_lo = last_bit - (word_end_c - code_first_c);
	localparam int code_hi = last_bit - (word_end_c - code_last_c);

	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] cnt_next;
	logic pre_sync;
	logic [1:0] type_sr;
	logic [4:0] code_sr;

	function automatic arc_ctl_t decode_instr(input logic [1:0] itype, input logic [4:0] code);
		arc_ctl_t d;
		d = '0;
		if (itype == type_arith) begin
			case (code)
				code_a_add_b: d.op = op_a_add_b;
				code_a_sub_b: d.op = op_a_sub_b;
				code_a_add_c: d.op = op_a_add_c;
				code_a_sub_c: d.op = op_a_sub_c;
				code_c_add_a: d.op = op_c_add_a;
				code_c_sub_a: d.op = op_c_sub_a;
				code_a_inc: d.op = op_a_inc;
				code_a_dec: d.op = op_a_dec;
				code_cmp_ab: d.op = op_cmp_ab;
				code_cmp_ac: d.op = op_cmp_ac;
				code_c_zero: d.op = op_c_zero_test;
				code_a_clr: d.op = op_a_clr;
				code_c_clr: d.op = op_c_clr;
				code_axb: d.op = op_axb;
				code_axc: d.op = op_axc;
				code_sla: d.op = op_sla;
				code_sra: d.op = op_sra;
				default: d.op = op_nop;
			endcase
		end else if (itype == type_misc) begin
			// LDC n carries the constant in bits 4..1
			if (!code[0]) begin
				d.op = op_ldc;
				d.const_n = code[4:1];
			end else if (code == code_clreg) begin
				d.op = op_clreg;
			end
		end
		case (d.op)
			op_a_add_b, op_a_sub_b, op_cmp_ab: d.operand_sel = opnd_b;
			op_a_add_c, op_a_sub_c, op_c_add_a, op_c_sub_a,
			op_cmp_ac, op_c_zero_test: d.operand_sel = opnd_c;
			op_a_inc, op_a_dec: d.operand_sel = opnd_one;
			default: d.operand_sel = opnd_none;
		endcase
		// Every op with a second operand runs through the ALU
		d.arith = (d.operand_sel != opnd_none);
		d.subtract = d.op inside {op_a_sub_b, op_a_sub_c, op_c_sub_a, op_a_dec,
			op_cmp_ab, op_cmp_ac};
		d.dest_a = d.op inside {op_a_add_b, op_a_sub_b, op_a_add_c, op_a_sub_c,
			op_a_inc, op_a_dec};
		d.dest_c = d.op inside {op_c_add_a, op_c_sub_a};
		return d;
	endfunction

	// Falling sync restarts the word, otherwise wrap at the end
	always_comb begin
		if ((pre_sync && !sync) || cnt == cnt_w'(last_bit))
			cnt_next = '0;
		else
			cnt_next = cnt + 1'b1;
	end

	assign strobe.t0 = (cnt == '0);
	assign strobe.t4k = (cnt[1:0] == 2'b00);
	assign strobe.t4km1 = (cnt[1:0] == 2'b11);
	assign strobe.t55 = (cnt == cnt_w'(last_bit));

	always_ff @(posedge cph2 or negedge ws) begin
		if (!ws) begin
			cnt <= '0;
			pre_sync <= 1'b0;
			start <= 1'b0;
			type_sr <= '0;
			code_sr <= '0;
			ctl <= '0;
		end else begin
			cnt <= cnt_next;
			pre_sync <= sync;
			// Registered so it lines up with bit-time 0
			start <= (cnt_next == '0);
			if (cnt >= cnt_w'(type_lo) && cnt <= cnt_w'(type_hi))
				type_sr <= {is, type_sr[1]};
			if (cnt >= cnt_w'(code_lo) && cnt <= cnt_w'(code_hi))
				code_sr <= {is, code_sr[4:1]};
			// Executes over the whole next word
			if (strobe.t55)
				ctl <= decode_instr(type_sr, code_sr);
		end
	end

endmodule

// ==== arc_op_pkg.sv ====
/*
 * Instruction encodings and decoded control for the chip.
 * Codes are the 5 opcode bits, type is the 2 bit field.
 */
package arc_op_pkg;

	typedef enum logic [1:0] {
		type_misc = 2'b00,
		type_arith = 2'b10
	} arc_type_e;

	// Kept operations, anything else runs as op_nop
	typedef enum logic [4:0] {
		op_nop, op_a_add_b, op_a_sub_b, op_a_add_c, op_a_sub_c,
		op_c_add_a, op_c_sub_a, op_a_inc, op_a_dec, op_cmp_ab,
		op_cmp_ac, op_c_zero_test, op_a_clr, op_c_clr, op_axb,
		op_axc, op_sla, op_sra, op_ldc, op_clreg
	} arc_op_e;

	// Second ALU operand
	typedef enum logic [1:0] {
		opnd_none, opnd_b, opnd_c, opnd_one
	} arc_opnd_e;

	typedef struct packed {
		arc_op_e op;
		logic arith;
		logic subtract;
		arc_opnd_e operand_sel;
		logic dest_a;
		logic dest_c;
		logic [3:0] const_n;
	} arc_ctl_t;

	// Arithmetic type opcodes
	localparam logic [4:0] code_a_add_b = 5'b11100;
	localparam logic [4:0] code_a_sub_b = 5'b11000;
	localparam logic [4:0] code_a_add_c = 5'b11110;
	localparam logic [4:0] code_a_sub_c = 5'b11010;
	localparam logic [4:0] code_c_add_a = 5'b01110;
	localparam logic [4:0] code_c_sub_a = 5'b01010;
	localparam logic [4:0] code_a_inc = 5'b11111;
	localparam logic [4:0] code_a_dec = 5'b11011;
	localparam logic [4:0] code_cmp_ab = 5'b10000;
	localparam logic [4:0] code_cmp_ac = 5'b00010;
	localparam logic [4:0] code_c_zero = 5'b01101;
	localparam logic [4:0] code_a_clr = 5'b10111;
	localparam logic [4:0] code_c_clr = 5'b00110;
	localparam logic [4:0] code_axb = 5'b11001;
	localparam logic [4:0] code_axc = 5'b11101;
	localparam logic [4:0] code_sla = 5'b01000;
	localparam logic [4:0] code_sra = 5'b10110;

	// Misc type, LDC n uses bit 0 = 0
	localparam logic [4:0] code_clreg = 5'b11101;

endpackage

// ==== arc_timing_pkg.sv ====
/*
 * Word timing for the arithmetic and register chip.
 * Bit-time positions of the instruction window and the strobe set.
 */
package arc_timing_pkg;

	// Bits in one BCD digit
	localparam int word_bits_c = 4;

	// Instruction type bits, LSB first
	localparam int type_first_c = 45;
	localparam int type_last_c = 46;

	// Opcode bits, LSB first
	localparam int code_first_c = 50;
	localparam int code_last_c = 54;

	// Last bit-time of a 14 digit word
	localparam int word_end_c = 55;

	// Strobes decoded from the bit counter
	typedef struct packed {
		// First bit of word
		logic t0;
		// First bit of a digit
		logic t4k;
		// Last bit of a digit
		logic t4km1;
		// Last bit of word
		logic t55;
	} arc_strobe_t;

endpackage
